// ==== hw/rob_alloc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module rob_alloc (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    alloc_valid,
    input  rob_pkg::commit_kind_e  alloc_kind,
    input  wire [`ROB_REG_W-1:0]   alloc_rd,
    input  wire                    alloc_pred_taken,
    output logic                   alloc_ready,
    output logic [`ROB_NICK_W-1:0] alloc_nick,
    output logic                   full,
    rob_alloc_if.alloc             a
);

    logic [`ROB_NICK_W-1:0] tail;
    logic [`ROB_NICK_W:0]   count;
    logic                   accept;

    assign full        = (count == `ROB_DEPTH);
    // no new entry while the buffer is being emptied
    assign alloc_ready = !full && !a.flush_now;
    assign accept      = alloc_valid && alloc_ready;
    assign alloc_nick  = tail;

    assign a.wr_en   = accept;
    assign a.wr_nick = tail;
    assign a.count   = count;

    // fresh entry, result fields wait for writeback
    always_comb begin
        a.wr_entry            = '0;
        a.wr_entry.kind       = alloc_kind;
        a.wr_entry.rd         = alloc_rd;
        a.wr_entry.pred_taken = alloc_pred_taken;
    end

    always_ff @(posedge clk) begin
        if (rst || a.flush_now) begin
            tail  <= '0;
            count <= '0;
        end else begin
            if (accept) begin
                tail <= tail + 1'b1;
            end
            case ({accept, a.retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= `ROB_DEPTH);

endmodule

`default_nettype wire

// ==== hw/rob_commit_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module rob_commit_ctrl (
    input  wire                    clk,
    input  wire                    rst,
    rob_head_if.ctrl               h,
    rob_alloc_if.ctrl              a,
    output logic                   rf_en,
    output logic [`ROB_REG_W-1:0]  rf_rd,
    output logic [`ROB_DATA_W-1:0] rf_data,
    output logic [`ROB_NICK_W-1:0] rf_nick,
    output logic                   store_en,
    output logic [`ROB_NICK_W-1:0] store_nick,
    output logic                   flush,
    output logic [`ROB_ADDR_W-1:0] redirect_pc
);

    logic [`ROB_NICK_W-1:0] head;
    logic                   head_ready;
    logic                   is_store;
    logic                   mispredict;

    assign h.head_nick = head;

    assign head_ready = (a.count != '0) && h.head_entry.done;
    assign is_store   = (h.head_entry.kind == rob_pkg::KIND_STORE);
    assign mispredict = (h.head_entry.kind == rob_pkg::KIND_BRANCH) &&
                        (h.head_entry.act_taken != h.head_entry.pred_taken);

    assign a.retire    = head_ready;
    // a wrong branch still retires, but takes everything younger with it
    assign a.flush_now = head_ready && mispredict;

    always_ff @(posedge clk) begin
        if (rst) begin
            head     <= '0;
            rf_en    <= 1'b0;
            store_en <= 1'b0;
            flush    <= 1'b0;
        end else begin
            rf_en    <= head_ready && !is_store;
            store_en <= head_ready && is_store;
            flush    <= a.flush_now;
            if (a.flush_now) begin
                head <= '0;
            end else if (a.retire) begin
                head <= head + 1'b1;
            end
        end
    end

    // commit payload, qualified by the strobes above
    always_ff @(posedge clk) begin
        if (head_ready) begin
            if (is_store) begin
                store_nick <= head;
            end else begin
                rf_rd   <= h.head_entry.rd;
                rf_data <= h.head_entry.data;
                rf_nick <= head;
            end
            if (mispredict) begin
                redirect_pc <= h.head_entry.target;
            end
        end
    end

    // the mispredict edge leaves nothing allocated
    a_flush_empties: assert property (@(posedge clk) disable iff (rst)
        flush |-> (a.count == '0));

endmodule

`default_nettype wire

// ==== hw/rob_defs.svh ====
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// number of buffer entries, kept a power of two
`define ROB_DEPTH 16

// nick width, log2 of the depth
`define ROB_NICK_W 4

// architectural register name width
`define ROB_REG_W 5

// result width
`define ROB_DATA_W 32

// pc width
`define ROB_ADDR_W 32

`endif

// ==== hw/rob_entry_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module rob_entry_store (
    input  wire        clk,
    input  wire        rst,
    rob_alloc_if.store a,
    rob_wb_if.dst      ex,
    rob_wb_if.dst      lsb,
    rob_head_if.store  h
);

    rob_pkg::rob_entry_t    mem [`ROB_DEPTH];
    // completion flags kept apart from the payload array
    logic [`ROB_DEPTH-1:0]  done_q;

    // payload writes, execute port last so it wins on a clash
    always_ff @(posedge clk) begin
        if (a.wr_en) begin
            mem[a.wr_nick] <= a.wr_entry;
        end
        if (lsb.en) begin
            mem[lsb.nick].data <= lsb.data;
        end
        if (ex.en) begin
            mem[ex.nick].data      <= ex.data;
            mem[ex.nick].act_taken <= ex.taken;
            mem[ex.nick].target    <= ex.target;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || a.flush_now) begin
            done_q <= '0;
        end else begin
            if (a.wr_en) begin
                done_q[a.wr_nick] <= 1'b0;
            end
            if (lsb.en) begin
                done_q[lsb.nick] <= 1'b1;
            end
            if (ex.en) begin
                done_q[ex.nick] <= 1'b1;
            end
        end
    end

    // head view with the live done flag
    always_comb begin
        h.head_entry      = mem[h.head_nick];
        h.head_entry.done = done_q[h.head_nick];
    end

    // each allocated entry gets exactly one result
    a_ex_once: assert property (@(posedge clk) disable iff (rst)
        ex.en |-> !done_q[ex.nick]);

    a_lsb_once: assert property (@(posedge clk) disable iff (rst)
        lsb.en |-> !done_q[lsb.nick]);

endmodule

`default_nettype wire

// ==== hw/rob_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

// allocation path plus retire/flush feedback from the commit side
interface rob_alloc_if;
    logic                   wr_en;
    logic [`ROB_NICK_W-1:0] wr_nick;
    rob_pkg::rob_entry_t    wr_entry;
    logic [`ROB_NICK_W:0]   count;
    logic                   retire;
    logic                   flush_now;

    modport alloc (output wr_en, wr_nick, wr_entry, count, input retire, flush_now);
    modport store (input wr_en, wr_nick, wr_entry, flush_now);
    modport ctrl (input count, output retire, flush_now);
endinterface

// one writeback port, strobe only
interface rob_wb_if;
    logic                   en;
    logic [`ROB_NICK_W-1:0] nick;
    logic [`ROB_DATA_W-1:0] data;
    logic                   taken;
    logic [`ROB_ADDR_W-1:0] target;

    modport src (output en, nick, data, taken, target);
    modport dst (input en, nick, data, taken, target);
endinterface

interface rob_head_if;
    logic [`ROB_NICK_W-1:0] head_nick;
    rob_pkg::rob_entry_t    head_entry;

    modport store (input head_nick, output head_entry);
    modport ctrl (output head_nick, input head_entry);
endinterface

`default_nettype wire

// ==== hw/rob_pkg.sv ====
`default_nettype none

`include "rob_defs.svh"

package rob_pkg;

    // how the head entry leaves the buffer
    typedef enum logic [1:0] {
        KIND_REG    = 2'd0,
        KIND_STORE  = 2'd1,
        KIND_BRANCH = 2'd2
    } commit_kind_e;

    typedef struct packed {
        commit_kind_e            kind;
        logic [`ROB_REG_W-1:0]   rd;
        logic                    pred_taken;
        // filled in by the execute writeback
        logic                    act_taken;
        logic                    done;
        logic [`ROB_DATA_W-1:0]  data;
        // redirect pc on mispredict
        logic [`ROB_ADDR_W-1:0]  target;
    } rob_entry_t;

endpackage

`default_nettype wire

// ==== hw/rob_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module rob_top (
    input  wire                    clk,
    input  wire                    rst,
    // allocation
    input  wire                    alloc_valid,
    output logic                   alloc_ready,
    input  rob_pkg::commit_kind_e  alloc_kind,
    input  wire [`ROB_REG_W-1:0]   alloc_rd,
    input  wire                    alloc_pred_taken,
    output logic [`ROB_NICK_W-1:0] alloc_nick,
    output logic                   full,
    // execute writeback
    input  wire                    ex_en,
    input  wire [`ROB_NICK_W-1:0]  ex_nick,
    input  wire [`ROB_DATA_W-1:0]  ex_data,
    input  wire                    ex_taken,
    input  wire [`ROB_ADDR_W-1:0]  ex_target,
    // load/store writeback
    input  wire                    lsb_en,
    input  wire [`ROB_NICK_W-1:0]  lsb_nick,
    input  wire [`ROB_DATA_W-1:0]  lsb_data,
    // commit
    output logic                   rf_en,
    output logic [`ROB_REG_W-1:0]  rf_rd,
    output logic [`ROB_DATA_W-1:0] rf_data,
    output logic [`ROB_NICK_W-1:0] rf_nick,
    output logic                   store_en,
    output logic [`ROB_NICK_W-1:0] store_nick,
    output logic                   flush,
    output logic [`ROB_ADDR_W-1:0] redirect_pc
);

    rob_alloc_if a_if ();
    rob_wb_if    ex_if ();
    rob_wb_if    lsb_if ();
    rob_head_if  h_if ();

    assign ex_if.en     = ex_en;
    assign ex_if.nick   = ex_nick;
    assign ex_if.data   = ex_data;
    assign ex_if.taken  = ex_taken;
    assign ex_if.target = ex_target;

    // load/store results carry no branch outcome
    assign lsb_if.en     = lsb_en;
    assign lsb_if.nick   = lsb_nick;
    assign lsb_if.data   = lsb_data;
    assign lsb_if.taken  = 1'b0;
    assign lsb_if.target = '0;

    rob_alloc i_alloc (
        .clk(clk), .rst(rst),
        .alloc_valid(alloc_valid), .alloc_kind(alloc_kind),
        .alloc_rd(alloc_rd), .alloc_pred_taken(alloc_pred_taken),
        .alloc_ready(alloc_ready), .alloc_nick(alloc_nick),
        .full(full), .a(a_if.alloc)
    );

    rob_entry_store i_store (
        .clk(clk), .rst(rst), .a(a_if.store),
        .ex(ex_if.dst), .lsb(lsb_if.dst), .h(h_if.store)
    );

    rob_commit_ctrl i_commit (
        .clk(clk), .rst(rst), .h(h_if.ctrl), .a(a_if.ctrl),
        .rf_en(rf_en), .rf_rd(rf_rd), .rf_data(rf_data), .rf_nick(rf_nick),
        .store_en(store_en), .store_nick(store_nick),
        .flush(flush), .redirect_pc(redirect_pc)
    );

endmodule

`default_nettype wire

// ==== rob_top.f ====
+incdir+hw
hw/rob_pkg.sv
hw/rob_ifs.sv
hw/rob_alloc.sv
hw/rob_entry_store.sv
hw/rob_commit_ctrl.sv
hw/rob_top.sv
test/tb_rob_top.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f rob_top.f --top-module tb_rob_top
out=$(./obj_dir/Vtb_rob_top || true)
echo "$out"
if echo "$out" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1

// ==== test/tb_rob_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module tb_rob_top;

    localparam int DEPTH       = `ROB_DEPTH;
    localparam int WAIT_LIMIT  = 2000;
    localparam int NOT_WRITTEN = 32'h7fff_ffff;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   alloc_valid;
    logic                   alloc_ready;
    rob_pkg::commit_kind_e  alloc_kind;
    logic [`ROB_REG_W-1:0]  alloc_rd;
    logic                   alloc_pred_taken;
    logic [`ROB_NICK_W-1:0] alloc_nick;
    logic                   full;
    logic                   ex_en;
    logic                   ex_taken;
    logic [`ROB_ADDR_W-1:0] ex_target;
    logic                   lsb_en;
    logic [`ROB_NICK_W-1:0] ex_nick, lsb_nick;
    logic [`ROB_DATA_W-1:0] ex_data, lsb_data;
    logic                   rf_en;
    logic [`ROB_REG_W-1:0]  rf_rd;
    logic [`ROB_DATA_W-1:0] rf_data;
    logic [`ROB_NICK_W-1:0] rf_nick;
    logic                   store_en;
    logic [`ROB_NICK_W-1:0] store_nick;
    logic                   flush;
    logic [`ROB_ADDR_W-1:0] redirect_pc;

    // expected entry per nick, result values chosen at allocation
    rob_pkg::rob_entry_t    sb [DEPTH];
    int                     wb_edge [DEPTH];
    logic [`ROB_NICK_W-1:0] order_q [$];
    logic [`ROB_NICK_W-1:0] pend_q [$];
    logic [31:0]            rng = 32'h3ea8_4ec7;
    int                     tail_model = 0;
    int                     cyc = 0;
    int                     tmo;
    int                     errors = 0;
    int                     timeouts = 0;
    int                     stores = 0;
    int                     flushes = 0;

    rob_top i_dut (.*);

    always #2 clk = ~clk;

    a_full_stalls: assert property (@(posedge clk) disable iff (rst) full |-> !alloc_ready)
        else begin
            errors++;
            $display("[ERROR] alloc_ready = %h while full = %h",
                     $sampled(alloc_ready), $sampled(full));
        end

    a_flush_with_rf: assert property (@(posedge clk) disable iff (rst) flush |-> rf_en)
        else begin
            errors++;
            $display("[ERROR] rf_en = %h while flush = %h", $sampled(rf_en), $sampled(flush));
        end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic bit mispredicted(input logic [`ROB_NICK_W-1:0] n);
        return (sb[n].kind == rob_pkg::KIND_BRANCH) && (sb[n].act_taken != sb[n].pred_taken);
    endfunction

    // wrong branch at the head already written back, so it retires this cycle
    function automatic bit flush_pending();
        if (order_q.size() == 0) begin
            return 1'b0;
        end
        return mispredicted(order_q[0]) && (wb_edge[order_q[0]] <= cyc);
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %s = %h, expected %h at cycle %0d", name, got, exp, cyc);
        end
    endtask

    task automatic note_fail(input string msg);
        errors++;
        $display("[ERROR] %s at cycle %0d", msg, cyc);
    endtask

    // registered commit outputs against the oldest queued entry
    task automatic check_commit();
        logic [`ROB_NICK_W-1:0] n;
        logic                   is_store;
        logic                   mis;
        if (!rf_en && !store_en) begin
            check_eq("flush", 32'(flush), 32'h0);
        end else if (order_q.size() == 0) begin
            note_fail("commit seen with no entry outstanding");
        end else begin
            n = order_q.pop_front();
            is_store = (sb[n].kind == rob_pkg::KIND_STORE);
            mis = mispredicted(n);
            assert (cyc > wb_edge[n]) else note_fail("commit before the head was written back");
            check_eq("store_en", 32'(store_en), 32'(is_store));
            check_eq("rf_en", 32'(rf_en), 32'(!is_store));
            if (is_store) begin
                stores++;
                check_eq("store_nick", 32'(store_nick), 32'(n));
            end else begin
                check_eq("rf_nick", 32'(rf_nick), 32'(n));
                check_eq("rf_rd", 32'(rf_rd), 32'(sb[n].rd));
                check_eq("rf_data", rf_data, sb[n].data);
            end
            check_eq("flush", 32'(flush), 32'(mis));
            if (mis) begin
                flushes++;
                check_eq("redirect_pc", redirect_pc, sb[n].target);
                // younger entries are dropped, nicks restart at 0
                order_q.delete();
                pend_q.delete();
                tail_model = 0;
            end
        end
        check_eq("full", 32'(full), 32'(order_q.size() == DEPTH));
    endtask

    task automatic drive_inputs(input bit do_alloc, input bit do_wb);
        logic [31:0]            r;
        logic [`ROB_NICK_W-1:0] n;
        int                     idx;
        bit                     to_ex;
        bit                     exp_ready;
        alloc_valid = 1'b0;
        ex_en = 1'b0;
        lsb_en = 1'b0;
        // up to two writebacks, random picks among pending nicks
        repeat (2) begin
            r = next_rand();
            if (do_wb && pend_q.size() > 0 && r[1:0] != 2'd0) begin
                idx = int'(r[31:8]) % pend_q.size();
                n = pend_q[idx];
                to_ex = (sb[n].kind == rob_pkg::KIND_BRANCH) ||
                        (sb[n].kind == rob_pkg::KIND_REG && r[2]);
                if (to_ex && !ex_en) begin
                    ex_en = 1'b1;
                    ex_nick = n;
                    ex_data = sb[n].data;
                    ex_taken = sb[n].act_taken;
                    ex_target = sb[n].target;
                end else if (!to_ex && !lsb_en) begin
                    lsb_en = 1'b1;
                    lsb_nick = n;
                    lsb_data = sb[n].data;
                end
                if ((ex_en && ex_nick == n) || (lsb_en && lsb_nick == n)) begin
                    wb_edge[n] = cyc + 1;
                    pend_q.delete(idx);
                end
            end
        end
        // no room, or the buffer empties at the coming edge
        exp_ready = (order_q.size() < DEPTH) && !flush_pending();
        check_eq("alloc_ready", 32'(alloc_ready), 32'(exp_ready));
        if (do_alloc) begin
            r = next_rand();
            alloc_valid = 1'b1;
            alloc_kind = (r[2:0] == 3'd0) ? rob_pkg::KIND_BRANCH :
                         (r[2:0] < 3'd3)  ? rob_pkg::KIND_STORE : rob_pkg::KIND_REG;
            alloc_rd = r[8:4];
            alloc_pred_taken = r[9];
            if (exp_ready) begin
                n = tail_model[`ROB_NICK_W-1:0];
                check_eq("alloc_nick", 32'(alloc_nick), 32'(n));
                sb[n] = '0;
                sb[n].kind = alloc_kind;
                sb[n].rd = alloc_rd;
                sb[n].pred_taken = alloc_pred_taken;
                sb[n].act_taken = (r[11:10] == 2'd0) ? !r[9] : r[9];
                sb[n].data = next_rand();
                sb[n].target = next_rand() & 32'hffff_fffc;
                wb_edge[n] = NOT_WRITTEN;
                order_q.push_back(n);
                pend_q.push_back(n);
                tail_model = (tail_model + 1) % DEPTH;
            end
        end
    endtask

    task automatic run_cycle(input bit do_alloc, input bit do_wb);
        @(posedge clk);
        cyc++;
        #1;
        check_commit();
        drive_inputs(do_alloc, do_wb);
    endtask

    initial begin
        rst = 1'b1;
        alloc_valid = 1'b0;
        alloc_kind = rob_pkg::KIND_REG;
        alloc_rd = '0;
        alloc_pred_taken = 1'b0;
        ex_en = 1'b0;
        ex_nick = '0;
        ex_data = '0;
        ex_taken = 1'b0;
        ex_target = '0;
        lsb_en = 1'b0;
        lsb_nick = '0;
        lsb_data = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        check_eq("rf_en", 32'(rf_en), 32'h0);
        check_eq("store_en", 32'(store_en), 32'h0);
        check_eq("flush", 32'(flush), 32'h0);
        check_eq("full", 32'(full), 32'h0);
        check_eq("alloc_ready", 32'(alloc_ready), 32'h1);
        // no writebacks yet, so the buffer runs full
        tmo = 0;
        while (!full && tmo < WAIT_LIMIT) begin
            run_cycle(1'b1, 1'b0);
            tmo++;
        end
        if (!full) begin
            timeouts++;
            $display("timeout while waiting for the buffer to fill");
        end
        repeat (6) run_cycle(1'b1, 1'b0);
        repeat (800) run_cycle(1'b1, 1'b1);
        tmo = 0;
        while (order_q.size() > 0 && tmo < WAIT_LIMIT) begin
            run_cycle(1'b0, 1'b1);
            tmo++;
        end
        if (order_q.size() > 0) begin
            timeouts++;
            $display("timeout while waiting for the buffer to drain");
        end
        repeat (4) run_cycle(1'b0, 1'b0);
        if (stores == 0 || flushes == 0) begin
            note_fail("stimulus never reached a store commit and a mispredict");
        end
        $display("errors: %0d, timeouts: %0d, stores: %0d, flushes: %0d",
                 errors, timeouts, stores, flushes);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
